//--- source/uart_alu_cfg.svh
`ifndef UART_ALU_CFG_SVH
`define UART_ALU_CFG_SVH

// Serial frame and byte width
`define UART_DATA_BITS 8

// Clocks per bit period
// Receiver samples at half of this after the start edge
`define UART_CLKS_PER_BIT 16

// Entries per byte FIFO
// Same depth on the receive and transmit side
`define FIFO_DEPTH 4

`endif

//--- source/uart_types_pkg.sv
package uart_types_pkg;

    ////////////////////
    // Serial line
    ////////////////////

    // Bit phase of a frame, shared by receiver and transmitter
    typedef enum logic [1:0] {
        idle  = 2'd0,
        start = 2'd1,
        data  = 2'd2,
        stop  = 2'd3
    } uart_line_state_e;

    ////////////////////
    // Byte queues
    ////////////////////

    // FIFO levels as seen by the consumer and producer
    typedef struct packed {
        logic empty;
        logic full;
    } fifo_status_t;

endpackage

//--- source/alu_types_pkg.sv
package alu_types_pkg;

    `include "uart_alu_cfg.svh"

    // Opcodes carried in the low 6 bits of the first byte
    typedef enum logic [5:0] {
        op_srl = 6'h02,
        op_sra = 6'h03,
        op_add = 6'h20,
        op_sub = 6'h22,
        op_and = 6'h24,
        op_or  = 6'h25,
        op_xor = 6'h26,
        op_nor = 6'h27
    } alu_opcode_e;

    // Sequencer phases, one per collected byte plus compute and push
    typedef enum logic [2:0] {
        get_opcode,
        get_op1,
        get_op2,
        issue,
        push
    } seq_state_e;

    // Assembled command, 22 bits
    typedef struct packed {
        alu_opcode_e                opcode;
        logic [`UART_DATA_BITS-1:0] operand_a;
        logic [`UART_DATA_BITS-1:0] operand_b;
    } alu_command_t;

endpackage

//--- source/uart_rx.sv
`timescale 1ns/1ps

`include "uart_alu_cfg.svh"

module uart_rx (
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic                       i_rx,
    output logic [`UART_DATA_BITS-1:0] o_byte,
    output logic                       o_valid
);
    import uart_types_pkg::*;

    localparam int unsigned CLKS  = `UART_CLKS_PER_BIT;
    localparam int unsigned CNT_W = $clog2(CLKS);
    localparam int unsigned IDX_W = $clog2(`UART_DATA_BITS);

    uart_line_state_e           state;
    logic [1:0]                 rx_sync;
    logic [CNT_W-1:0]           tick_count;
    logic [IDX_W-1:0]           bit_index;
    logic [`UART_DATA_BITS-1:0] shift_reg;
    logic                       rx_bit;
    logic                       half_bit;
    logic                       full_bit;

    // Synchronised line level, oldest flop
    assign rx_bit   = rx_sync[1];
    // Mid start bit, then every bit period after it
    assign half_bit = (tick_count == CNT_W'(CLKS / 2 - 1));
    assign full_bit = (tick_count == CNT_W'(CLKS - 1));

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            rx_sync    <= 2'b11;
            state      <= idle;
            tick_count <= '0;
            bit_index  <= '0;
            o_valid    <= 1'b0;
        end else begin
            rx_sync    <= {rx_sync[0], i_rx};
            tick_count <= tick_count + 1'b1;
            o_valid    <= 1'b0;
            case (state)
                idle: begin
                    tick_count <= '0;
                    // Falling start edge
                    if (!rx_bit) begin
                        state <= start;
                    end
                end
                start: begin
                    if (half_bit) begin
                        tick_count <= '0;
                        bit_index  <= '0;
                        // Glitch if the line went back high
                        state      <= rx_bit ? idle : data;
                    end
                end
                data: begin
                    if (full_bit) begin
                        tick_count <= '0;
                        bit_index  <= bit_index + 1'b1;
                        if (bit_index == IDX_W'(`UART_DATA_BITS - 1)) begin
                            state <= stop;
                        end
                    end
                end
                stop: begin
                    if (full_bit) begin
                        // Bad stop bit drops the byte
                        o_valid <= rx_bit;
                        state   <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    ////////////////////
    // Payload
    ////////////////////

    // LSB first, so new bits enter at the top
    always_ff @(posedge i_clock) begin
        if (state == data && full_bit) begin
            shift_reg <= {rx_bit, shift_reg[`UART_DATA_BITS-1:1]};
        end
        if (state == stop && full_bit) begin
            o_byte <= shift_reg;
        end
    end

endmodule

//--- source/byte_fifo.sv
`timescale 1ns/1ps

`include "uart_alu_cfg.svh"

module byte_fifo (
    input  logic                         i_clock,
    input  logic                         i_reset,
    input  logic                         i_push,
    input  logic [`UART_DATA_BITS-1:0]   i_push_data,
    input  logic                         i_pop,
    output logic [`UART_DATA_BITS-1:0]   o_pop_data,
    output uart_types_pkg::fifo_status_t o_status
);
    localparam int unsigned DEPTH = `FIFO_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [`UART_DATA_BITS-1:0] mem [DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           count;
    logic                       do_push;
    logic                       do_pop;

    // Qualified strobes, the buffer never over or underflows
    assign do_push = i_push && !o_status.full;
    assign do_pop  = i_pop && !o_status.empty;

    // Head of the queue is always on the output
    assign o_pop_data     = mem[rd_ptr];
    assign o_status.empty = (count == '0);
    assign o_status.full  = (count == CNT_W'(DEPTH));

    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge i_clock) begin
        if (do_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

endmodule

//--- source/alu_command_sequencer.sv
`timescale 1ns/1ps

`include "uart_alu_cfg.svh"

module alu_command_sequencer (
    input  logic                         i_clock,
    input  logic                         i_reset,
    input  logic [`UART_DATA_BITS-1:0]   i_rx_data,
    input  uart_types_pkg::fifo_status_t i_rx_status,
    output logic                         o_rx_pop,
    output alu_types_pkg::alu_command_t  o_command,
    input  logic [`UART_DATA_BITS-1:0]   i_result,
    input  uart_types_pkg::fifo_status_t i_tx_status,
    output logic                         o_tx_push,
    output logic [`UART_DATA_BITS-1:0]   o_tx_data
);
    import alu_types_pkg::*;

    localparam int unsigned OPC_W = $bits(alu_opcode_e);

    seq_state_e state;
    logic       byte_ready;

    // A byte is at the head and the last pop has already taken effect
    assign byte_ready = !i_rx_status.empty && !o_rx_pop;

    ////////////////////
    // State machine
    ////////////////////

    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            state     <= get_opcode;
            o_rx_pop  <= 1'b0;
            o_tx_push <= 1'b0;
        end else begin
            // Strobes are single cycle pulses
            o_rx_pop  <= 1'b0;
            o_tx_push <= 1'b0;
            case (state)
                get_opcode: begin
                    if (byte_ready) begin
                        o_rx_pop <= 1'b1;
                        state    <= get_op1;
                    end
                end
                get_op1: begin
                    if (byte_ready) begin
                        o_rx_pop <= 1'b1;
                        state    <= get_op2;
                    end
                end
                get_op2: begin
                    if (byte_ready) begin
                        o_rx_pop <= 1'b1;
                        state    <= issue;
                    end
                end
                // Command complete, result captured below
                issue: state <= push;
                push: begin
                    // Held here while the output queue is full
                    if (!i_tx_status.full) begin
                        o_tx_push <= 1'b1;
                        state     <= get_opcode;
                    end
                end
                default: state <= get_opcode;
            endcase
        end
    end

    ////////////////////
    // Command and result
    ////////////////////

    always_ff @(posedge i_clock) begin
        // Upper two opcode byte bits are ignored
        if (state == get_opcode && byte_ready) begin
            o_command.opcode <= alu_opcode_e'(i_rx_data[OPC_W-1:0]);
        end
        if (state == get_op1 && byte_ready) begin
            o_command.operand_a <= i_rx_data;
        end
        if (state == get_op2 && byte_ready) begin
            o_command.operand_b <= i_rx_data;
        end
        if (state == issue) begin
            o_tx_data <= i_result;
        end
    end

endmodule

//--- source/alu_core.sv
`timescale 1ns/1ps

`include "uart_alu_cfg.svh"

module alu_core (
    input  alu_types_pkg::alu_command_t i_command,
    output logic [`UART_DATA_BITS-1:0]  o_result
);
    import alu_types_pkg::*;

    localparam int unsigned SHIFT_W = $clog2(`UART_DATA_BITS);

    logic [`UART_DATA_BITS-1:0] a;
    logic [`UART_DATA_BITS-1:0] b;
    logic [SHIFT_W-1:0]         shamt;

    assign a     = i_command.operand_a;
    assign b     = i_command.operand_b;
    // Shift amount from the low bits of operand b only
    assign shamt = b[SHIFT_W-1:0];

    always_comb begin
        case (i_command.opcode)
            // Sums wrap at the data width
            op_add:  o_result = a + b;
            op_sub:  o_result = a - b;
            op_and:  o_result = a & b;
            op_or:   o_result = a | b;
            op_xor:  o_result = a ^ b;
            op_nor:  o_result = ~(a | b);
            // Sign bit fills in from the top
            op_sra:  o_result = $signed(a) >>> shamt;
            op_srl:  o_result = a >> shamt;
            // Unknown opcode
            default: o_result = '0;
        endcase
    end

endmodule

//--- source/uart_tx.sv
`timescale 1ns/1ps

`include "uart_alu_cfg.svh"

module uart_tx (
    input  logic                         i_clock,
    input  logic                         i_reset,
    input  logic [`UART_DATA_BITS-1:0]   i_data,
    input  uart_types_pkg::fifo_status_t i_status,
    output logic                         o_pop,
    output logic                         o_tx
);
    import uart_types_pkg::*;

    localparam int unsigned CLKS  = `UART_CLKS_PER_BIT;
    localparam int unsigned CNT_W = $clog2(CLKS);
    localparam int unsigned IDX_W = $clog2(`UART_DATA_BITS);

    uart_line_state_e           state;
    logic [CNT_W-1:0]           tick_count;
    logic [IDX_W-1:0]           bit_index;
    logic [`UART_DATA_BITS-1:0] shift_reg;
    logic                       bit_done;

    assign bit_done = (tick_count == CNT_W'(CLKS - 1));

    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            state      <= idle;
            tick_count <= '0;
            bit_index  <= '0;
            o_pop      <= 1'b0;
            o_tx       <= 1'b1;
        end else begin
            o_pop      <= 1'b0;
            tick_count <= bit_done ? '0 : tick_count + 1'b1;
            case (state)
                idle: begin
                    tick_count <= '0;
                    o_tx       <= 1'b1;
                    // Take the head byte and begin the start bit
                    if (!i_status.empty) begin
                        o_pop <= 1'b1;
                        o_tx  <= 1'b0;
                        state <= start;
                    end
                end
                start: begin
                    if (bit_done) begin
                        bit_index <= '0;
                        o_tx      <= shift_reg[0];
                        state     <= data;
                    end
                end
                data: begin
                    if (bit_done) begin
                        bit_index <= bit_index + 1'b1;
                        // Next data bit or the stop bit after the last one
                        o_tx      <= (bit_index == IDX_W'(`UART_DATA_BITS - 1)) ?
                                     1'b1 : shift_reg[1];
                        if (bit_index == IDX_W'(`UART_DATA_BITS - 1)) begin
                            state <= stop;
                        end
                    end
                end
                stop: begin
                    if (bit_done) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Byte loads on the pop, then moves down one bit per period
    always_ff @(posedge i_clock) begin
        if (state == idle && !i_status.empty) begin
            shift_reg <= i_data;
        end else if (state == data && bit_done) begin
            shift_reg <= {1'b1, shift_reg[`UART_DATA_BITS-1:1]};
        end
    end

endmodule

//--- source/uart_alu_top.sv
`timescale 1ns/1ps

`include "uart_alu_cfg.svh"

module uart_alu_top (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_rx,
    output logic o_tx
);
    import uart_types_pkg::*;
    import alu_types_pkg::*;

    ////////////////////
    // Input side
    ////////////////////

    logic [`UART_DATA_BITS-1:0] rx_byte;
    logic                       rx_valid;
    logic                       rx_push;
    logic [`UART_DATA_BITS-1:0] rx_data;
    fifo_status_t               rx_status;
    logic                       rx_pop;

    uart_rx uart_rx_i (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_rx    (i_rx),
        .o_byte  (rx_byte),
        .o_valid (rx_valid)
    );

    // Byte arriving into a full queue is dropped
    assign rx_push = rx_valid && !rx_status.full;

    byte_fifo rx_fifo (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_push      (rx_push),
        .i_push_data (rx_byte),
        .i_pop       (rx_pop),
        .o_pop_data  (rx_data),
        .o_status    (rx_status)
    );

    ////////////////////
    // Processing
    ////////////////////

    alu_command_t               command;
    logic [`UART_DATA_BITS-1:0] alu_result;
    logic                       tx_push;
    logic [`UART_DATA_BITS-1:0] tx_push_data;
    logic [`UART_DATA_BITS-1:0] tx_data;
    fifo_status_t               tx_status;
    logic                       tx_pop;

    alu_command_sequencer alu_command_sequencer_i (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_rx_data   (rx_data),
        .i_rx_status (rx_status),
        .o_rx_pop    (rx_pop),
        .o_command   (command),
        .i_result    (alu_result),
        .i_tx_status (tx_status),
        .o_tx_push   (tx_push),
        .o_tx_data   (tx_push_data)
    );

    // Result comes back in the same cycle
    alu_core alu_core_i (
        .i_command (command),
        .o_result  (alu_result)
    );

    ////////////////////
    // Output side
    ////////////////////

    byte_fifo tx_fifo (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_push      (tx_push),
        .i_push_data (tx_push_data),
        .i_pop       (tx_pop),
        .o_pop_data  (tx_data),
        .o_status    (tx_status)
    );

    uart_tx uart_tx_i (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_data   (tx_data),
        .i_status (tx_status),
        .o_pop    (tx_pop),
        .o_tx     (o_tx)
    );

endmodule

//--- tests/uart_alu_sva.sv
`timescale 1ns/1ps

module uart_alu_sva (
    input logic                             i_clock,
    input logic                             i_reset,
    input logic                             i_rx_pop,
    input uart_types_pkg::fifo_status_t     i_rx_status,
    input logic                             i_tx_push,
    input logic                             i_tx_pop,
    input uart_types_pkg::fifo_status_t     i_tx_status,
    input uart_types_pkg::uart_line_state_e i_tx_state,
    input logic                             i_tx_line
);
    import uart_types_pkg::*;

    ////////////////////
    // FIFO strobes
    ////////////////////

    // No underflow on either queue and no overflow on the transmit queue
    rx_pop_not_empty: assert property (
        @(posedge i_clock) disable iff (i_reset) i_rx_pop |-> !i_rx_status.empty
    ) else $error("rx FIFO popped while empty");

    tx_pop_not_empty: assert property (
        @(posedge i_clock) disable iff (i_reset) i_tx_pop |-> !i_tx_status.empty
    ) else $error("tx FIFO popped while empty");

    tx_push_not_full: assert property (
        @(posedge i_clock) disable iff (i_reset) i_tx_push |-> !i_tx_status.full
    ) else $error("tx FIFO pushed while full");

    // Single cycle pulses
    rx_pop_pulse: assert property (
        @(posedge i_clock) disable iff (i_reset) i_rx_pop |=> !i_rx_pop
    ) else $error("rx pop strobe longer than one cycle");

    tx_push_pulse: assert property (
        @(posedge i_clock) disable iff (i_reset) i_tx_push |=> !i_tx_push
    ) else $error("tx push strobe longer than one cycle");

    tx_pop_pulse: assert property (
        @(posedge i_clock) disable iff (i_reset) i_tx_pop |=> !i_tx_pop
    ) else $error("tx pop strobe longer than one cycle");

    ////////////////////
    // Line level
    ////////////////////

    // Reset already seen by an earlier edge
    reset_line_high: assert property (
        @(posedge i_clock) (i_reset && $past(i_reset)) |-> i_tx_line
    ) else $error("o_tx low during reset");

    first_cycle_line_high: assert property (
        @(posedge i_clock) $fell(i_reset) |-> i_tx_line
    ) else $error("o_tx low in the first cycle after reset");

    // Idle transmitter keeps the mark level
    idle_line_high: assert property (
        @(posedge i_clock) disable iff (i_reset) (i_tx_state == idle) |-> i_tx_line
    ) else $error("o_tx low while the transmitter is idle");

endmodule

bind uart_alu_top uart_alu_sva uart_alu_sva_i (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_rx_pop    (rx_pop),
    .i_rx_status (rx_status),
    .i_tx_push   (tx_push),
    .i_tx_pop    (tx_pop),
    .i_tx_status (tx_status),
    .i_tx_state  (uart_tx_i.state),
    .i_tx_line   (o_tx)
);

//--- tests/uart_alu_tb.sv
`timescale 1ns/1ps

`include "uart_alu_cfg.svh"

module uart_alu_tb;

    localparam int unsigned BIT_CLKS   = `UART_CLKS_PER_BIT;
    localparam int unsigned DW         = `UART_DATA_BITS;
    // Longest wait for a start bit is six frames
    localparam int unsigned RX_TIMEOUT = 6 * 10 * BIT_CLKS;

    // Opcode bytes of the command set
    localparam logic [7:0] OP_ADD = 8'h20;
    localparam logic [7:0] OP_SUB = 8'h22;
    localparam logic [7:0] OP_AND = 8'h24;
    localparam logic [7:0] OP_OR  = 8'h25;
    localparam logic [7:0] OP_XOR = 8'h26;
    localparam logic [7:0] OP_NOR = 8'h27;
    localparam logic [7:0] OP_SRA = 8'h03;
    localparam logic [7:0] OP_SRL = 8'h02;

    logic i_clock;
    logic i_reset;
    logic i_rx;
    logic o_tx;

    int seed;
    int checks;
    int mismatches;
    int timeouts;
    int line_errors;

    uart_alu_top uart_alu_top_i (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_rx    (i_rx),
        .o_tx    (o_tx)
    );

    // 100 ns period
    always #50 i_clock = ~i_clock;

    ////////////////////
    // Serial helpers
    ////////////////////

    // Just past the rising edge where inputs change and outputs are settled
    task automatic step();
        @(posedge i_clock);
        #1;
    endtask

    // Start bit, data LSB first, stop bit
    task automatic send_byte(input logic [DW-1:0] value);
        logic [DW+1:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < DW + 2; i++) begin
            i_rx = frame[i];
            repeat (BIT_CLKS) step();
        end
    endtask

    task automatic send_command(input logic [7:0] opc, input logic [7:0] a,
                                input logic [7:0] b);
        send_byte(opc);
        send_byte(a);
        send_byte(b);
    endtask

    // Waits for the start edge then samples each bit at mid period
    task automatic receive_byte(output logic [DW-1:0] value);
        int waited;
        waited = 0;
        value  = '0;
        while (o_tx !== 1'b0 && waited < RX_TIMEOUT) begin
            step();
            waited++;
        end
        if (o_tx !== 1'b0) begin
            timeouts++;
            $display("timeout at %0t: no start bit on o_tx within %0d cycles",
                     $time, RX_TIMEOUT);
        end else begin
            repeat (BIT_CLKS / 2) step();
            for (int i = 0; i < DW; i++) begin
                repeat (BIT_CLKS) step();
                value[i] = o_tx;
            end
            repeat (BIT_CLKS) step();
            assert (o_tx === 1'b1) else begin
                line_errors++;
                $display("mismatch at %0t: stop bit of a result frame was low", $time);
            end
        end
    endtask

    ////////////////////
    // Checking
    ////////////////////

    // Low 6 bits pick the operation and shifts use the low 3 bits of b
    function automatic logic [7:0] expected_result(input logic [7:0] opc_byte,
                                                   input logic [7:0] a,
                                                   input logic [7:0] b);
        logic [7:0] r;
        r = a;
        case (opc_byte[5:0])
            OP_ADD[5:0]: r = 8'((int'(a) + int'(b)) % 256);
            OP_SUB[5:0]: r = 8'((256 + int'(a) - int'(b)) % 256);
            OP_AND[5:0]: r = a & b;
            OP_OR[5:0]:  r = a | b;
            OP_XOR[5:0]: r = a ^ b;
            OP_NOR[5:0]: r = ~(a | b);
            // One position per step with the sign copied in
            OP_SRA[5:0]: repeat (int'(b[2:0])) r = {r[7], r[7:1]};
            OP_SRL[5:0]: repeat (int'(b[2:0])) r = {1'b0, r[7:1]};
            default:     r = 8'h00;
        endcase
        return r;
    endfunction

    task automatic check_result(input logic [7:0] opc, input logic [7:0] a,
                                input logic [7:0] b, input logic [7:0] got);
        logic [7:0] want;
        want = expected_result(opc, a, b);
        checks++;
        assert (got === want) else begin
            mismatches++;
            $display("mismatch at %0t: op %02h a %02h b %02h gave %02h, expected %02h",
                     $time, opc, a, b, got, want);
        end
    endtask

    // Result may start before the last stop bit ends, so listen in parallel
    task automatic run_command(input logic [7:0] opc, input logic [7:0] a,
                               input logic [7:0] b);
        logic [7:0] got;
        fork
            send_command(opc, a, b);
            receive_byte(got);
        join
        check_result(opc, a, b, got);
    endtask

    // Four commands with no gap and results collected in order
    task automatic run_burst();
        logic [7:0] opcs [4];
        logic [7:0] as [4];
        logic [7:0] bs [4];
        logic [7:0] gots [4];
        opcs = '{OP_XOR, OP_SRA, OP_ADD, OP_NOR};
        for (int i = 0; i < 4; i++) begin
            as[i] = 8'($random(seed));
            bs[i] = 8'($random(seed));
        end
        fork
            for (int i = 0; i < 4; i++) begin
                send_command(opcs[i], as[i], bs[i]);
            end
            for (int i = 0; i < 4; i++) begin
                receive_byte(gots[i]);
            end
        join
        for (int i = 0; i < 4; i++) begin
            check_result(opcs[i], as[i], bs[i], gots[i]);
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] ops [6];
        seed        = 32'he547_6e19;
        checks      = 0;
        mismatches  = 0;
        timeouts    = 0;
        line_errors = 0;
        i_clock     = 1'b0;
        i_reset     = 1'b1;
        i_rx        = 1'b1;
        repeat (16) @(posedge i_clock);
        #1;
        i_reset = 1'b0;

        // No frame expected on a quiet line
        for (int i = 0; i < 3 * 10 * BIT_CLKS; i++) begin
            step();
            assert (o_tx === 1'b1) else begin
                line_errors++;
                $display("mismatch at %0t: o_tx left the idle level with no command sent",
                         $time);
            end
        end

        // Logic and arithmetic with random operands
        ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOR};
        foreach (ops[i]) begin
            repeat (2) begin
                a = 8'($random(seed));
                b = 8'($random(seed));
                run_command(ops[i], a, b);
            end
        end

        // Negative operand a with every shift amount and noise above bit 2
        for (int sh = 0; sh < 8; sh++) begin
            a = 8'($random(seed)) | 8'h80;
            b = {5'($random(seed)), 3'(sh)};
            run_command(OP_SRA, a, b);
            run_command(OP_SRL, a, b);
        end

        // Unknown opcodes give zero
        a = 8'($random(seed));
        b = 8'($random(seed));
        run_command(8'h00, a, b);
        run_command(8'h21, a, b);
        run_command(8'hff, a, b);
        // Upper two bits ignored
        run_command({2'b11, OP_ADD[5:0]}, a, b);
        run_command({2'b10, OP_SUB[5:0]}, a, b);
        run_command({2'b01, OP_SRA[5:0]}, a | 8'h80, b);

        run_burst();

        $display("checks %0d, mismatches %0d, timeouts %0d, line errors %0d",
                 checks, mismatches, timeouts, line_errors);
        if (checks > 0 && mismatches == 0 && timeouts == 0 && line_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- uart_alu_top.f
+incdir+source
source/uart_types_pkg.sv
source/alu_types_pkg.sv
source/uart_rx.sv
source/byte_fifo.sv
source/alu_command_sequencer.sv
source/alu_core.sv
source/uart_tx.sv
source/uart_alu_top.sv
tests/uart_alu_sva.sv
tests/uart_alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the UART ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f uart_alu_top.f --top-module uart_alu_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/Vuart_alu_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1
